/* common/ig_consts.svh */
`ifndef IG_CONSTS_SVH
`define IG_CONSTS_SVH

// ----------------------------------------
// image geometry
// ----------------------------------------

// image width in pixels
`define IG_IMG_W 8
// image height in pixels
`define IG_IMG_H 8

// pixel address width, covers W*H locations
`define IG_ADDR_W 6

// ----------------------------------------
// data widths
// ----------------------------------------

// grayscale pixel
`define IG_PIX_W 8
// signed difference, pixel plus two bits
`define IG_DIFF_W 10

`endif

/* common/ig_pkg.sv */
package ig_pkg;

`include "ig_consts.svh"

    // one grayscale sample
    typedef logic [`IG_PIX_W-1:0] pixel_t;

    // raster address into either memory
    typedef logic [`IG_ADDR_W-1:0] addr_t;

    // fetched pixel with its own address
    typedef struct packed {
        logic   valid;
        pixel_t pixel;
        addr_t  addr;
    } pix_beat_t;

    // gradient word, gx in upper half like the memory word
    typedef struct packed {
        logic signed [`IG_DIFF_W-1:0] gx;
        logic signed [`IG_DIFF_W-1:0] gy;
    } grad_t;

    // gradient with its target address
    typedef struct packed {
        logic  valid;
        grad_t grad;
        addr_t addr;
    } grad_beat_t;

    // neighbourhood of pixel at addr
    typedef struct packed {
        logic   valid;
        addr_t  addr;
        pixel_t cur;
        pixel_t right;
        pixel_t below;
    } win_t;

endpackage

/* rtl/img_fetch.sv */
`timescale 1ns/1ns

`include "ig_consts.svh"

module img_fetch (
    input  logic              clk,
    input  logic              reset,
    output logic              img_rd,
    output ig_pkg::addr_t     img_addr,
    input  ig_pkg::pixel_t    img_di,
    output ig_pkg::pix_beat_t pix
);
    import ig_pkg::*;

    // last raster address of the frame
    localparam int unsigned LAST_ADDR = `IG_IMG_W * `IG_IMG_H - 1;

    // set once the whole frame has been requested
    logic finished;

    // read issued last cycle, data arrives now
    logic  rd_q;
    addr_t addr_q;

    // ----------------------------------------
    // read address generator
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            img_rd   <= 1'b0;
            img_addr <= '0;
            finished <= 1'b0;
        end else if (img_rd) begin
            if (img_addr == addr_t'(LAST_ADDR)) begin
                // frame fully requested, stop for good
                img_rd   <= 1'b0;
                finished <= 1'b1;
            end else begin
                img_addr <= img_addr + 1'b1;
            end
        end else if (!finished) begin
            // first cycle out of reset
            img_rd <= 1'b1;
        end
    end

    // ----------------------------------------
    // pair returned data with its address
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_q <= 1'b0;
        end else begin
            rd_q <= img_rd;
        end
    end

    // address copy only matters while rd_q is set
    always_ff @(posedge clk) begin
        addr_q <= img_addr;
    end

    // memory has one-cycle latency, so data lines up with the copies
    assign pix.valid = rd_q;
    assign pix.pixel = img_di;
    assign pix.addr  = addr_q;

endmodule

/* gradient/grad_window.sv */
`timescale 1ns/1ns

`include "ig_consts.svh"

module grad_window (
    input  logic              clk,
    input  logic              reset,
    input  ig_pkg::pix_beat_t pix,
    output ig_pkg::win_t      win
);
    import ig_pkg::*;

    localparam int unsigned W = `IG_IMG_W;

    // stored taps, dly[0] newest
    // together with the incoming pixel this is W+1 deep
    pixel_t dly [W];

    // window registers
    logic   win_valid;
    addr_t  win_addr;
    pixel_t win_cur;
    pixel_t win_right;
    pixel_t win_below;

    // ----------------------------------------
    // delay line, one row plus one pixel
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (pix.valid) begin
            dly[0] <= pix.pixel;
            for (int k = 1; k < W; k++) begin
                dly[k] <= dly[k-1];
            end
        end
    end

    // ----------------------------------------
    // window output
    // ----------------------------------------
    // incoming addr a completes window for i = a - W
    // oldest tap is pixel i, next one is i+1
    always_ff @(posedge clk) begin
        if (reset) begin
            win_valid <= 1'b0;
        end else begin
            // first row only fills the line
            win_valid <= pix.valid && (pix.addr >= addr_t'(W));
        end
    end

    always_ff @(posedge clk) begin
        win_addr  <= pix.addr - addr_t'(W);
        win_cur   <= dly[W-1];
        win_right <= dly[W-2];
        win_below <= pix.pixel;
    end

    assign win.valid = win_valid;
    assign win.addr  = win_addr;
    assign win.cur   = win_cur;
    assign win.right = win_right;
    assign win.below = win_below;

endmodule

/* gradient/grad_calc.sv */
`timescale 1ns/1ns

`include "ig_consts.svh"

module grad_calc (
    input  logic               clk,
    input  logic               reset,
    input  ig_pkg::win_t       win,
    output ig_pkg::grad_beat_t grad
);
    import ig_pkg::*;

    localparam int unsigned W  = `IG_IMG_W;
    localparam int unsigned DW = `IG_DIFF_W;
    localparam int unsigned PW = `IG_PIX_W;

    // pixels widened to signed difference width
    logic signed [DW-1:0] cur_s;
    logic signed [DW-1:0] right_s;
    logic signed [DW-1:0] below_s;

    // right neighbour is on the next row here
    logic last_col;

    logic  grad_valid;
    grad_t grad_q;
    addr_t addr_q;

    // pixels are unsigned, so pad with zeros
    assign cur_s   = $signed({{(DW-PW){1'b0}}, win.cur});
    assign right_s = $signed({{(DW-PW){1'b0}}, win.right});
    assign below_s = $signed({{(DW-PW){1'b0}}, win.below});

    // column border test
    assign last_col = (win.addr % addr_t'(W)) == addr_t'(W - 1);

    // ----------------------------------------
    // filter and subtract
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            grad_valid <= 1'b0;
        end else begin
            grad_valid <= win.valid && !last_col;
        end
    end

    always_ff @(posedge clk) begin
        grad_q.gx <= right_s - cur_s;
        grad_q.gy <= below_s - cur_s;
        addr_q    <= win.addr;
    end

    assign grad.valid = grad_valid;
    assign grad.grad  = grad_q;
    assign grad.addr  = addr_q;

endmodule

/* rtl/grad_writer.sv */
`timescale 1ns/1ns

`include "ig_consts.svh"

module grad_writer (
    input  logic               clk,
    input  logic               reset,
    input  ig_pkg::grad_beat_t grad,
    output logic               grad_wr,
    output ig_pkg::addr_t      grad_addr,
    output ig_pkg::grad_t      grad_do,
    output logic               done
);
    import ig_pkg::*;

    // interior positions, border is never written
    localparam int unsigned N_WR = (`IG_IMG_W - 1) * (`IG_IMG_H - 1);

    // writes already taken by the memory
    addr_t wr_cnt;

    // ----------------------------------------
    // write port
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            grad_wr <= 1'b0;
        end else begin
            grad_wr <= grad.valid;
        end
    end

    always_ff @(posedge clk) begin
        grad_addr <= grad.addr;
        grad_do   <= grad.grad;
    end

    // ----------------------------------------
    // write count and done
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_cnt <= '0;
            done   <= 1'b0;
        end else if (grad_wr) begin
            wr_cnt <= wr_cnt + 1'b1;
            // final write happens this cycle
            if (wr_cnt == addr_t'(N_WR - 1)) begin
                done <= 1'b1;
            end
        end
    end

endmodule

/* rtl/ig.sv */
`timescale 1ns/1ns

module ig (
    input  logic           clk,
    input  logic           reset,
    // image memory read port
    output logic           img_rd,
    output ig_pkg::addr_t  img_addr,
    input  ig_pkg::pixel_t img_di,
    // gradient memory write port
    output logic           grad_wr,
    output ig_pkg::addr_t  grad_addr,
    output ig_pkg::grad_t  grad_do,
    output logic           done
);
    import ig_pkg::*;

    // ----------------------------------------
    // stage links
    // ----------------------------------------
    // valid bit only, every stage always accepts
    pix_beat_t  pix;
    win_t       win;
    grad_beat_t grad;

    // raster read, one beat per pixel
    img_fetch u_fetch (
        .clk      (clk),
        .reset    (reset),
        .img_rd   (img_rd),
        .img_addr (img_addr),
        .img_di   (img_di),
        .pix      (pix)
    );

    // row plus one delay line
    grad_window u_window (
        .clk   (clk),
        .reset (reset),
        .pix   (pix),
        .win   (win)
    );

    // column filter and differences
    grad_calc u_calc (
        .clk   (clk),
        .reset (reset),
        .win   (win),
        .grad  (grad)
    );

    // memory write and end of frame
    grad_writer u_writer (
        .clk       (clk),
        .reset     (reset),
        .grad      (grad),
        .grad_wr   (grad_wr),
        .grad_addr (grad_addr),
        .grad_do   (grad_do),
        .done      (done)
    );

endmodule

/* tests/ig_tb.sv */
`timescale 1ns/1ns

`include "ig_consts.svh"

module ig_tb;
    import ig_pkg::*;

    localparam int W      = `IG_IMG_W;
    localparam int H      = `IG_IMG_H;
    localparam int N_PIX  = W * H;
    localparam int N_GRAD = (W - 1) * (H - 1);
    // pixels then address and word per interior pixel
    localparam int N_PAT  = N_PIX + 2 * N_GRAD;
    localparam int LIMIT  = 4 * (N_PIX + W + 10);
    // cycles watched after done rises
    localparam int HOLD   = 20;
    localparam logic [19:0] SENTINEL = '1;

    logic   clk;
    logic   reset;
    logic   img_rd;
    addr_t  img_addr;
    pixel_t img_di;
    logic   grad_wr;
    addr_t  grad_addr;
    grad_t  grad_do;
    logic   done;

    // memory models and expected results
    logic [31:0] pat [N_PAT];
    pixel_t      img_mem [N_PIX];
    logic [19:0] exp_word [N_PIX];
    logic        exp_listed [N_PIX];
    logic [19:0] grad_mem [N_PIX];

    // run state
    int    cycles;
    int    rd_cnt;
    int    wr_cnt;
    int    post_done;
    logic  rd_ended;
    logic  pend_rd;
    addr_t pend_addr;

    ig dut (
        .clk       (clk),
        .reset     (reset),
        .img_rd    (img_rd),
        .img_addr  (img_addr),
        .img_di    (img_di),
        .grad_wr   (grad_wr),
        .grad_addr (grad_addr),
        .grad_do   (grad_do),
        .done      (done)
    );

    // 40 ns period
    always #20 clk = ~clk;

    // ----------------------------------------
    // helpers
    // ----------------------------------------
    task automatic expect_equal(input string what, input logic [31:0] got,
                                input logic [31:0] exp);
        if (got !== exp) begin
            $display("error at %0t ns: %s, got 0x%0h, expected 0x%0h",
                     $time, what, got, exp);
            $display("Simulation failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic abort_run(input string why);
        $display("Simulation failed");
        $fatal(1, "%s", why);
    endtask

    // image memory returns data one cycle after the read cycle
    task automatic drive_image_memory;
        if (pend_rd) begin
            img_di = img_mem[pend_addr];
        end
        pend_rd   = img_rd;
        pend_addr = img_addr;
    endtask

    // reads form one unbroken burst with addresses counting up
    task automatic watch_reads;
        if (img_rd) begin
            if (rd_ended) begin
                abort_run("img_rd went high again after the read burst had ended");
            end else begin
                expect_equal("read address", 32'(img_addr), 32'(rd_cnt));
                rd_cnt++;
            end
        end else if (rd_cnt > 0) begin
            rd_ended = 1'b1;
        end
    endtask

    // word is captured on the coming edge
    task automatic watch_writes;
        if (grad_wr) begin
            expect_equal("done high during a write", 32'(done), 32'(0));
            expect_equal("write to unlisted address", 32'(exp_listed[grad_addr]), 32'(1));
            expect_equal("address written twice", 32'(grad_mem[grad_addr]), 32'(SENTINEL));
            expect_equal("gradient word", 32'(grad_do), 32'(exp_word[grad_addr]));
            grad_mem[grad_addr] = grad_do;
            wr_cnt++;
        end
    endtask

    task automatic watch_done;
        if (done) begin
            if (post_done == 0) begin
                expect_equal("write count when done rose", 32'(wr_cnt), 32'(N_GRAD));
            end
            post_done++;
        end else if (post_done > 0) begin
            expect_equal("done held until reset", 32'(done), 32'(1));
        end
    endtask

    // ----------------------------------------
    // main sequence
    // ----------------------------------------
    initial begin
        addr_t a;

        clk       = 1'b0;
        reset     = 1'b1;
        img_di    = '0;
        cycles    = 0;
        rd_cnt    = 0;
        wr_cnt    = 0;
        post_done = 0;
        rd_ended  = 1'b0;
        pend_rd   = 1'b0;
        pend_addr = '0;

        // entries the file does not reach keep this marker
        // pattern values never use the upper bits
        for (int k = 0; k < N_PAT; k++) begin
            pat[k] = ~32'(k);
        end
        $readmemh("tests/ig_patterns.txt", pat);
        if (pat[N_PAT-1] === ~32'(N_PAT - 1)) begin
            abort_run("pattern file tests/ig_patterns.txt is missing or too short");
        end
        for (int k = 0; k < N_PIX; k++) begin
            img_mem[k]    = pixel_t'(pat[k]);
            exp_listed[k] = 1'b0;
            grad_mem[k]   = SENTINEL;
        end
        for (int k = 0; k < N_GRAD; k++) begin
            a             = addr_t'(pat[N_PIX + 2 * k]);
            exp_listed[a] = 1'b1;
            exp_word[a]   = 20'(pat[N_PIX + 2 * k + 1]);
        end

        // hold reset for two cycles and release 2 ns after the edge
        repeat (2) @(posedge clk);
        #2;
        reset = 1'b0;
        expect_equal("img_rd after reset", 32'(img_rd), 32'(0));
        expect_equal("grad_wr after reset", 32'(grad_wr), 32'(0));
        expect_equal("done after reset", 32'(done), 32'(0));

        while (post_done <= HOLD) begin
            @(posedge clk);
            #2;
            cycles++;
            if (cycles > LIMIT) begin
                abort_run("timeout, done did not rise and hold within the cycle limit");
            end else begin
                drive_image_memory();
                watch_reads();
                watch_writes();
                watch_done();
            end
        end

        // read total and untouched border
        expect_equal("read cycles", 32'(rd_cnt), 32'(N_PIX));
        for (int k = 0; k < N_PIX; k++) begin
            if (!exp_listed[k]) begin
                expect_equal("border location written", 32'(grad_mem[k]), 32'(SENTINEL));
            end
        end

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

/* tests/ig_patterns.txt */
// first 64 values: image pixels in raster order, eight per line (one image row)
// then one line per interior pixel: address, expected word {gx, gy}
00 23 46 69 8C AF D2 F5
28 4B 6E 91 B4 D7 FA 1D
50 73 96 B9 DC FF 22 45
78 9B BE E1 04 27 4A 6D
A0 C3 E6 09 2C 4F 72 95
C8 EB 0E 31 54 77 9A BD
F0 13 36 59 7C 9F C2 E5
18 3B 5E 81 A4 C7 EA 0D
00 08C28
01 08C28
02 08C28
03 08C28
04 08C28
05 08C28
06 08C28
08 08C28
09 08C28
0A 08C28
0B 08C28
0C 08C28
0D 08C28
0E C8F28
10 08C28
11 08C28
12 08C28
13 08C28
14 08F28
15 C8F28
16 08C28
18 08C28
19 08C28
1A 08C28
1B C8F28
1C 08C28
1D 08C28
1E 08C28
20 08C28
21 08C28
22 C8F28
23 08C28
24 08C28
25 08C28
26 08C28
28 08C28
29 C8F28
2A 08C28
2B 08C28
2C 08C28
2D 08C28
2E 08C28
30 C8F28
31 08C28
32 08C28
33 08C28
34 08C28
35 08C28
36 08C28

/* flist.f */
+incdir+common
common/ig_pkg.sv
rtl/img_fetch.sv
gradient/grad_window.sv
gradient/grad_calc.sv
rtl/grad_writer.sv
rtl/ig.sv
tests/ig_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the image gradient testbench with Verilator
# exit status is nonzero if the build fails or the testbench fails

cd "$(dirname "$0")" || exit 1

verilator --binary --timing \
    -f flist.f \
    --top-module ig_tb \
    --Mdir obj_dir \
    -o ig_tb_sim
status=$?
if [ $status -ne 0 ]; then
    echo "build failed with status $status"
    exit $status
fi

./obj_dir/ig_tb_sim
status=$?
if [ $status -ne 0 ]; then
    echo "simulation run failed with status $status"
    exit $status
fi

exit 0
